/* include/apb_island_macros.svh */
`ifndef APB_ISLAND_MACROS_SVH
`define APB_ISLAND_MACROS_SVH

// ----------------------------------------------------------------------
// bus widths
`define APB_ADDR_W 32
`define APB_DATA_W 32
`define APB_STRB_W (`APB_DATA_W / 8)

// ----------------------------------------------------------------------
// region codes, taken from paddr[31:28]
`define FAST_REGION    4'h0
`define SLOW_REGION_LO 4'hA
`define SLOW_REGION_HI 4'hB

// ----------------------------------------------------------------------
// slow clock ratio in eighths, 20 means 2.5 fast cycles per slow cycle
`define RATIO_FRAC_BITS 3
`define DELAY_RATIO_X8  20

`define SRAM_WORDS 256
`define FAST_WAIT  0
`define SLOW_WAIT  2

`endif

/* rtl/apb_pkg.sv */
`default_nettype none

`include "apb_island_macros.svh"

package apb_pkg;

    // ------------------------------------------------------------------
    // request from a completer's point of view, 74 bits.
    typedef struct packed {
        logic [`APB_ADDR_W-1:0] paddr;
        logic                   psel;
        logic                   penable;
        logic [2:0]             pprot;     // carried through, never checked.
        logic                   pwrite;
        logic [`APB_DATA_W-1:0] pwdata;
        logic [`APB_STRB_W-1:0] pstrb;
    } apb_req_t;

    // ------------------------------------------------------------------
    // response back to the requester, 34 bits.
    typedef struct packed {
        logic                   pready;
        logic [`APB_DATA_W-1:0] prdata;    // only meaningful with pready.
        logic                   pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* rtl/apb_delayer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apb_island_macros.svh"

module apb_delayer (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire apb_pkg::apb_req_t up_req,
    output apb_pkg::apb_rsp_t      up_rsp,
    output apb_pkg::apb_req_t      dn_req,
    input  wire apb_pkg::apb_rsp_t dn_rsp
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        HOLD = 2'd2
    } state_t;

    localparam int ACC_W = 16;

    state_t            state;
    logic [ACC_W-1:0]  acc;                // fixed point while in REQ, whole cycles in HOLD.
    apb_pkg::apb_rsp_t rsp_q;
    logic              dn_done;
    logic              hold_done;

    assign dn_done   = (state == REQ) && dn_rsp.pready;
    assign hold_done = (state == HOLD) && (acc == '0);

    // ------------------------------------------------------------------
    // transfer FSM
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (up_req.psel) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (dn_rsp.pready) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (acc == '0) begin
                        state <= IDLE;     // master samples pready in this cycle.
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // latency accumulator
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else if (state == IDLE) begin
            acc <= '0;
        end else if (dn_done) begin
            acc <= acc >> `RATIO_FRAC_BITS;    // drop the fraction, floor of W x ratio.
        end else if (state == REQ) begin
            acc <= acc + ACC_W'(`DELAY_RATIO_X8);
        end else if (acc != '0) begin
            acc <= acc - 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rsp_q <= '0;
        end else if (dn_done) begin
            rsp_q <= dn_rsp;
        end
    end

    // slave is released once it has answered.
    always_comb begin
        dn_req = up_req;
        if (state == HOLD) begin
            dn_req.psel    = 1'b0;
            dn_req.penable = 1'b0;
        end
    end

    always_comb begin
        up_rsp = '0;
        if (hold_done) begin
            up_rsp = rsp_q;
        end
    end

endmodule

`default_nettype wire

/* rtl/apb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apb_island_macros.svh"

module apb_decoder (
    input  wire apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t      rsp,
    output apb_pkg::apb_req_t      fast_req,
    output apb_pkg::apb_req_t      slow_req,
    input  wire apb_pkg::apb_rsp_t fast_rsp,
    input  wire apb_pkg::apb_rsp_t slow_rsp
);

    logic [3:0] region;
    logic       hit_fast;
    logic       hit_slow;
    logic       err_done;

    // ------------------------------------------------------------------
    // address window
    assign region   = req.paddr[`APB_ADDR_W-1 -: 4];
    assign hit_fast = (region == `FAST_REGION);
    assign hit_slow = (region >= `SLOW_REGION_LO) && (region <= `SLOW_REGION_HI);

    // unmapped transfers finish in their first access cycle.
    assign err_done = req.psel && req.penable && !hit_fast && !hit_slow;

    // ------------------------------------------------------------------
    // request fan-out
    always_comb begin
        fast_req         = req;
        fast_req.psel    = req.psel && hit_fast;
        fast_req.penable = req.penable && hit_fast;
    end

    always_comb begin
        slow_req         = req;
        slow_req.psel    = req.psel && hit_slow;
        slow_req.penable = req.penable && hit_slow;
    end

    // ------------------------------------------------------------------
    // response mux
    always_comb begin
        if (hit_fast) begin
            rsp = fast_rsp;
        end else if (hit_slow) begin
            rsp = slow_rsp;
        end else begin
            rsp.pready  = err_done;
            rsp.prdata  = '0;
            rsp.pslverr = err_done;
        end
    end

endmodule

`default_nettype wire

/* rtl/apb_sram_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apb_island_macros.svh"

module apb_sram_slave #(
    parameter int WAIT_STATES = 0
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t      rsp
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);
    localparam int CNT_W = 8;

    logic [`APB_DATA_W-1:0] mem [`SRAM_WORDS];
    logic [CNT_W-1:0]       wait_cnt;
    logic [IDX_W-1:0]       idx;
    logic                   setup;
    logic                   access;
    logic                   ready;
    logic                   bad_addr;

    // ------------------------------------------------------------------
    // address check
    assign idx      = req.paddr[IDX_W+1:2];
    assign bad_addr = (|req.paddr[1:0]) || (|req.paddr[27:IDX_W+2]);

    assign setup  = req.psel && !req.penable;
    assign access = req.psel && req.penable;
    assign ready  = access && (wait_cnt == CNT_W'(WAIT_STATES));

    // ------------------------------------------------------------------
    // wait states, counted from the first access cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (setup) begin
            wait_cnt <= '0;
        end else if (access && !ready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (ready && req.pwrite && !bad_addr) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (req.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= req.pwdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // response
    always_comb begin
        rsp.pready  = ready;
        rsp.pslverr = ready && bad_addr;
        rsp.prdata  = '0;
        if (ready && !req.pwrite && !bad_addr) begin
            rsp.prdata = mem[idx];
        end
    end

endmodule

`default_nettype wire

/* rtl/apb_island_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apb_island_macros.svh"

module apb_island_top (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire apb_pkg::apb_req_t host_req,
    output apb_pkg::apb_rsp_t      host_rsp
);

    apb_pkg::apb_req_t fast_req;
    apb_pkg::apb_rsp_t fast_rsp;
    apb_pkg::apb_req_t slow_req;
    apb_pkg::apb_rsp_t slow_rsp;
    apb_pkg::apb_req_t dly_req;   // slow branch after the delayer.
    apb_pkg::apb_rsp_t dly_rsp;

    apb_decoder u_decoder (
        .req      (host_req),
        .rsp      (host_rsp),
        .fast_req (fast_req),
        .slow_req (slow_req),
        .fast_rsp (fast_rsp),
        .slow_rsp (slow_rsp)
    );

    apb_sram_slave #(.WAIT_STATES(`FAST_WAIT)) fast_mem (
        .clock (clock),
        .reset (reset),
        .req   (fast_req),
        .rsp   (fast_rsp)
    );

    apb_delayer u_delayer (
        .clock  (clock),
        .reset  (reset),
        .up_req (slow_req),
        .up_rsp (slow_rsp),
        .dn_req (dly_req),
        .dn_rsp (dly_rsp)
    );

    apb_sram_slave #(.WAIT_STATES(`SLOW_WAIT)) slow_mem (
        .clock (clock),
        .reset (reset),
        .req   (dly_req),
        .rsp   (dly_rsp)
    );

endmodule

`default_nettype wire

/* dv/apb_island_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apb_island_macros.svh"

module apb_island_tb;

    localparam int TIMEOUT = 50;
    localparam int N_RAND  = 40;
    localparam int IDX_W   = $clog2(`SRAM_WORDS);

    logic              clock;
    logic              reset;
    apb_pkg::apb_req_t host_req;
    apb_pkg::apb_rsp_t host_rsp;

    logic [`APB_DATA_W-1:0] model_fast [int];    // word index to data.
    logic [`APB_DATA_W-1:0] model_slow [int];
    int                     errs;
    int                     tests_passed;
    int                     tests_failed;
    int unsigned            seed;

    apb_island_top uut (
        .clock    (clock),
        .reset    (reset),
        .host_req (host_req),
        .host_rsp (host_rsp)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] make_addr(input logic [3:0] region, input int unsigned word);
        return {region, 28'(word << 2)};
    endfunction

    function automatic logic is_slow(input logic [3:0] region);
        return (region >= `SLOW_REGION_LO) && (region <= `SLOW_REGION_HI);
    endfunction

    // kind 0 fast, 1 slow, 2 misaligned, 3 beyond depth, other unmapped.
    function automatic logic [31:0] rand_addr(input int kind);
        logic [3:0]  region;
        int unsigned word;
        region = 4'($urandom_range(`SLOW_REGION_LO, `SLOW_REGION_HI));
        if ($urandom_range(0, 1)) begin
            region = `FAST_REGION;
        end
        word = $urandom_range(0, `SRAM_WORDS - 1);
        case (kind)
            0: region = `FAST_REGION;
            1: region = 4'($urandom_range(`SLOW_REGION_LO, `SLOW_REGION_HI));
            2: return make_addr(region, word) | 32'($urandom_range(1, 3));
            3: return make_addr(region, word + `SRAM_WORDS * $urandom_range(1, 1023));
            default: begin
                region = 4'($urandom_range(`SLOW_REGION_HI + 1, 15));
                if ($urandom_range(0, 1)) begin
                    region = 4'($urandom_range(1, `SLOW_REGION_LO - 1));
                end
            end
        endcase
        return make_addr(region, word);
    endfunction

    function automatic int expected_cycles(input logic [31:0] addr);
        if (addr[31:28] == `FAST_REGION) begin
            return 1 + `FAST_WAIT;
        end else if (is_slow(addr[31:28])) begin
            return 2 + `SLOW_WAIT + (`SLOW_WAIT * `DELAY_RATIO_X8) / (1 << `RATIO_FRAC_BITS);
        end
        return 1;    // decoder error completion.
    endfunction

    function automatic logic [31:0] model_word(input logic fast, input int word);
        if (fast && model_fast.exists(word)) begin
            return model_fast[word];
        end else if (!fast && model_slow.exists(word)) begin
            return model_slow[word];
        end
        return '0;
    endfunction

    // ------------------------------------------------------------------
    // APB master, one transfer starting at the next falling edge
    task automatic apb_xfer(input logic [31:0] addr, input logic write,
                            input logic [31:0] wdata, input logic [3:0] strb,
                            output apb_pkg::apb_rsp_t rsp, output int cycles);
        int waited;
        @(negedge clock);
        host_req.paddr   = addr;
        host_req.psel    = 1'b1;
        host_req.penable = 1'b0;
        host_req.pprot   = 3'($urandom);
        host_req.pwrite  = write;
        host_req.pwdata  = wdata;
        host_req.pstrb   = strb;
        @(negedge clock);
        host_req.penable = 1'b1;
        cycles = 1;
        waited = 0;
        @(posedge clock);
        while (!host_rsp.pready && waited < TIMEOUT) begin
            waited++;
            cycles++;
            @(posedge clock);
        end
        if (!host_rsp.pready) begin
            $display("timeout: no pready within %0d cycles for address %h", TIMEOUT, addr);
            $display("** FAIL **");
            $finish;
        end else begin
            rsp = host_rsp;
        end
    endtask

    task automatic check_xfer(input logic [31:0] addr, input logic write,
                              input logic [31:0] wdata, input logic [3:0] strb);
        apb_pkg::apb_rsp_t rsp;
        int                cycles;
        logic              fast;
        logic              unmapped;
        logic              bad;
        int                word;
        logic [31:0]       exp_data;
        logic [31:0]       cur;
        fast = (addr[31:28] == `FAST_REGION);
        unmapped = !(fast || is_slow(addr[31:28]));
        word = int'(addr[27:2]);
        bad = unmapped || (addr[1:0] != 2'b00) || (word >= `SRAM_WORDS);
        cur = model_word(fast, word);
        exp_data = unmapped ? '0 : cur;
        apb_xfer(addr, write, wdata, strb, rsp, cycles);
        if (rsp.pslverr !== bad) begin
            errs++;
            $display("FAILED %0t: addr %h pslverr %b, expected %b", $time, addr, rsp.pslverr, bad);
        end
        if ((unmapped || !(bad || write)) && rsp.prdata !== exp_data) begin
            errs++;
            $display("FAILED %0t: addr %h prdata %h, expected %h", $time, addr, rsp.prdata,
                     exp_data);
        end
        if (cycles != expected_cycles(addr)) begin
            errs++;
            $display("FAILED %0t: addr %h pready in cycle %0d, expected %0d", $time, addr,
                     cycles, expected_cycles(addr));
        end
        if (!bad && write) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (strb[b]) begin
                    cur[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            if (fast) begin
                model_fast[word] = cur;
            end else begin
                model_slow[word] = cur;
            end
        end
    endtask

    task automatic end_test(input string name);
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
        errs = 0;
    endtask

    // ------------------------------------------------------------------
    // test sequence
    initial begin
        logic [31:0] addr;
        seed = $urandom(70);
        clock = 1'b0;
        reset = 1'b1;
        host_req = '0;
        errs = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        if (host_rsp.pready !== 1'b0) begin
            errs++;
            $display("FAILED %0t: pready high right after reset", $time);
        end
        end_test("reset");
        for (int w = 0; w < `SRAM_WORDS; w++) begin    // both memories start from known data.
            check_xfer(make_addr(`FAST_REGION, w), 1'b1, $urandom, 4'hF);
            check_xfer(rand_addr(1) & 32'hF000_0000 | make_addr(4'h0, w), 1'b1, $urandom, 4'hF);
        end
        end_test("fill");
        repeat (N_RAND) check_xfer(rand_addr(0), 1'($urandom_range(0, 1)), $urandom, 4'hF);
        end_test("fast random");
        repeat (N_RAND) check_xfer(rand_addr(1), 1'($urandom_range(0, 1)), $urandom, 4'hF);
        end_test("slow random");
        for (int r = 0; r < 2; r++) begin
            repeat (N_RAND / 2) begin
                addr = rand_addr(r);
                check_xfer(addr, 1'b1, $urandom, 4'($urandom_range(1, 14)));
                check_xfer(addr, 1'b0, $urandom, 4'h0);
            end
        end
        end_test("partial strobes");
        repeat (N_RAND) begin
            addr = rand_addr($urandom_range(2, 3));
            check_xfer(addr, 1'($urandom_range(0, 1)), $urandom, 4'hF);
            check_xfer(make_addr(addr[31:28], addr[2 +: IDX_W]), 1'b0, $urandom, 4'h0);
        end
        end_test("bad address");
        repeat (N_RAND) check_xfer(rand_addr(4), 1'($urandom_range(0, 1)), $urandom, 4'hF);
        end_test("unmapped");
        repeat (2 * N_RAND) begin
            check_xfer(rand_addr($urandom_range(0, 4)), 1'($urandom_range(0, 1)), $urandom,
                       4'($urandom_range(1, 15)));
        end
        end_test("back to back mix");
        @(negedge clock);
        host_req.psel    = 1'b0;
        host_req.penable = 1'b0;
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
rtl/apb_pkg.sv
rtl/apb_delayer.sv
rtl/apb_decoder.sv
rtl/apb_sram_slave.sv
rtl/apb_island_top.sv
dv/apb_island_tb.sv

/* Bender.yml */
package:
  name: apb_island

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/apb_pkg.sv
      - rtl/apb_delayer.sv
      - rtl/apb_decoder.sv
      - rtl/apb_sram_slave.sv
      - rtl/apb_island_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/apb_island_tb.sv
